//--- Bender.yml
package:
  name: alu_coprocessor

sources:
  - include_dirs:
      - .
    files:
      - alu_pkg.sv
      - aluOpIf.sv
      - shiftUnit.sv
      - seqMultiplier.sv
      - aluControl.sv
      - operandRegs.sv
      - aluCore.sv
      - aluCoprocessor.sv
  - target: test
    include_dirs:
      - .
    files:
      - aluCoprocessor_sva.sv
      - tb_aluCoprocessor.sv

//--- aluControl.sv
`timescale 1ns/1ps
`include "alu_defines.svh"

module aluControl (
    input  logic                         clk,
    input  logic                         arstN,
    // Write address and data
    input  logic                         awvalid,
    output logic                         awready,
    input  alu_pkg::regAddrT             awaddr,
    input  logic                         wvalid,
    output logic                         wready,
    input  logic [`ALU_AXI_DATA_W-1:0]   wdata,
    // Write response
    output logic                         bvalid,
    input  logic                         bready,
    output alu_pkg::axiRespT             bresp,
    // Read address and data
    input  logic                         arvalid,
    output logic                         arready,
    input  alu_pkg::regAddrT             araddr,
    output logic                         rvalid,
    input  logic                         rready,
    output logic [`ALU_AXI_DATA_W-1:0]   rdata,
    output alu_pkg::axiRespT             rresp,
    // Execution request
    aluOpIf.ctrl                         op,
    // Register file side
    output logic                         wrData1,
    output logic                         wrData2,
    output alu_pkg::operandT             wrValue,
    output logic                         busy,
    input  logic [`ALU_AXI_DATA_W-1:0]   statusWord
);

    alu_pkg::ctrlStateT state;
    logic writeHs;
    logic ctrlOk;
    alu_pkg::axiRespT writeResp;
    alu_pkg::axiRespT readResp;
    logic [`ALU_AXI_DATA_W-1:0] readData;

    // Address and data taken together, only from IDLE
    assign writeHs = (state == alu_pkg::IDLE) && awvalid && wvalid;
    assign awready = writeHs;
    assign wready = writeHs;

    // Reads wait while any write channel is pending
    assign arready = (state == alu_pkg::IDLE) && arvalid && !awvalid && !wvalid;

    assign bvalid = (state == alu_pkg::WRESP) || (state == alu_pkg::EXEC);
    assign rvalid = (state == alu_pkg::RDATA);

    // Operand writes land on the handshake edge
    assign wrData1 = writeHs && (awaddr == `ALU_REG_DATA1);
    assign wrData2 = writeHs && (awaddr == `ALU_REG_DATA2);
    assign wrValue = wdata[`ALU_DATA_W-1:0];

    // Launch only when the unit is free
    assign ctrlOk = writeHs && (awaddr == `ALU_REG_CTRL) && !busy;

    // Write response decode
    always_comb begin
        case (awaddr)
            `ALU_REG_DATA1, `ALU_REG_DATA2: writeResp = `ALU_RESP_OKAY;
            `ALU_REG_CTRL: writeResp = busy ? `ALU_RESP_SLVERR : `ALU_RESP_OKAY;
            // Status is read-only, rest unmapped
            default: writeResp = `ALU_RESP_SLVERR;
        endcase
    end

    // Read decode
    always_comb begin
        readData = '0;
        readResp = `ALU_RESP_OKAY;
        case (araddr)
            `ALU_REG_STATUS: readData = statusWord;
            // Operand and control registers read back as zero
            `ALU_REG_DATA1, `ALU_REG_DATA2, `ALU_REG_CTRL: readData = '0;
            default: readResp = `ALU_RESP_SLVERR;
        endcase
    end

    // One transaction at a time
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= alu_pkg::IDLE;
            bresp <= `ALU_RESP_OKAY;
            rresp <= `ALU_RESP_OKAY;
            rdata <= '0;
        end else begin
            case (state)
                alu_pkg::IDLE: begin
                    if (writeHs) begin
                        state <= ctrlOk ? alu_pkg::EXEC : alu_pkg::WRESP;
                        bresp <= writeResp;
                    end else if (arready) begin
                        state <= alu_pkg::RDATA;
                        rdata <= readData;
                        rresp <= readResp;
                    end
                end
                // Operation runs on its own, only the response is awaited
                alu_pkg::WRESP, alu_pkg::EXEC: begin
                    if (bready) begin
                        state <= alu_pkg::IDLE;
                    end
                end
                alu_pkg::RDATA: begin
                    if (rready) begin
                        state <= alu_pkg::IDLE;
                    end
                end
                default: state <= alu_pkg::IDLE;
            endcase
        end
    end

    // Start pulse and busy, independent of bus stalls
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            op.start <= 1'b0;
            op.opcode <= '0;
            busy <= 1'b0;
        end else begin
            op.start <= ctrlOk;
            if (ctrlOk) begin
                op.opcode <= wdata[`ALU_OP_W-1:0];
            end
            // Done can never coincide with a launch
            if (op.done) begin
                busy <= 1'b0;
            end else if (ctrlOk) begin
                busy <= 1'b1;
            end
        end
    end

endmodule

//--- aluCoprocessor.sv
`timescale 1ns/1ps
`include "alu_defines.svh"

module aluCoprocessor (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         awvalid,
    output logic                         awready,
    input  alu_pkg::regAddrT             awaddr,
    input  logic                         wvalid,
    output logic                         wready,
    input  logic [`ALU_AXI_DATA_W-1:0]   wdata,
    output logic                         bvalid,
    input  logic                         bready,
    output alu_pkg::axiRespT             bresp,
    input  logic                         arvalid,
    output logic                         arready,
    input  alu_pkg::regAddrT             araddr,
    output logic                         rvalid,
    input  logic                         rready,
    output logic [`ALU_AXI_DATA_W-1:0]   rdata,
    output alu_pkg::axiRespT             rresp
);

    // Control to register file
    logic wrData1;
    logic wrData2;
    alu_pkg::operandT wrValue;
    logic busy;
    logic [`ALU_AXI_DATA_W-1:0] statusWord;

    // Register file to execution
    alu_pkg::operandT data1;
    alu_pkg::operandT data2;

    aluOpIf opBus ();

    aluControl control (
        .clk        (clk),
        .arstN      (arstN),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .op         (opBus.ctrl),
        .wrData1    (wrData1),
        .wrData2    (wrData2),
        .wrValue    (wrValue),
        .busy       (busy),
        .statusWord (statusWord)
    );

    operandRegs regs (
        .clk        (clk),
        .arstN      (arstN),
        .wrData1    (wrData1),
        .wrData2    (wrData2),
        .wrValue    (wrValue),
        .busy       (busy),
        .op         (opBus.mon),
        .data1      (data1),
        .data2      (data2),
        .statusWord (statusWord)
    );

    aluCore core (
        .clk   (clk),
        .arstN (arstN),
        .data1 (data1),
        .data2 (data2),
        .op    (opBus.exec)
    );

endmodule

//--- aluCoprocessor_sva.sv
`timescale 1ns/1ps
`include "alu_defines.svh"

module aluCoprocessorSva (
    input logic                         clk,
    input logic                         arstN,
    input logic                         awvalid,
    input logic                         awready,
    input logic                         wvalid,
    input logic                         wready,
    input logic                         bvalid,
    input logic                         bready,
    input alu_pkg::axiRespT             bresp,
    input logic                         arvalid,
    input logic                         arready,
    input logic                         rvalid,
    input logic                         rready,
    input logic [`ALU_AXI_DATA_W-1:0]   rdata,
    input alu_pkg::axiRespT             rresp,
    input logic                         busy,
    input logic                         start,
    input logic                         done
);

    int failCount = 0;

    // Response held and unchanged under back-pressure
    bHold: assert property (@(posedge clk) disable iff (!arstN)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            failCount++;
            $error("bvalid or bresp changed before bready");
        end

    rHold: assert property (@(posedge clk) disable iff (!arstN)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            failCount++;
            $error("rvalid, rdata or rresp changed before rready");
        end

    // Responses only after a handshake
    bAfterHs: assert property (@(posedge clk) disable iff (!arstN)
        $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
        else begin
            failCount++;
            $error("bvalid without a write handshake");
        end

    rAfterHs: assert property (@(posedge clk) disable iff (!arstN)
        $rose(rvalid) |-> $past(arvalid && arready))
        else begin
            failCount++;
            $error("rvalid without a read handshake");
        end

    // Both readies together and the write response in the next cycle
    readyPair: assert property (@(posedge clk) disable iff (!arstN)
        awready || wready |-> (awready && wready) ##1 bvalid)
        else begin
            failCount++;
            $error("awready and wready split or no write response in the next cycle");
        end

    // Busy set with start and cleared after done
    busyStart: assert property (@(posedge clk) disable iff (!arstN) $rose(busy) |-> start)
        else begin
            failCount++;
            $error("busy rose without start");
        end

    busyClear: assert property (@(posedge clk) disable iff (!arstN) done |=> !busy)
        else begin
            failCount++;
            $error("busy still set after done");
        end

    resetQuiet: assert property (@(posedge clk)
        !arstN |-> !awready && !wready && !arready && !bvalid && !rvalid
                   && !start && !done && !busy)
        else begin
            failCount++;
            $error("output active during reset");
        end

endmodule

bind aluCoprocessor aluCoprocessorSva protocolChecks (
    .clk     (clk),
    .arstN   (arstN),
    .awvalid (awvalid),
    .awready (awready),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .busy    (busy),
    .start   (opBus.start),
    .done    (opBus.done)
);

//--- aluCore.sv
`timescale 1ns/1ps
`include "alu_defines.svh"

module aluCore (
    input  logic             clk,
    input  logic             arstN,
    input  alu_pkg::operandT data1,
    input  alu_pkg::operandT data2,
    aluOpIf.exec             op
);

    alu_pkg::operandT shifted;
    alu_pkg::operandT mulProduct;
    logic mulFinish;
    alu_pkg::operandT immResult;
    alu_pkg::operandT resultQ;
    alu_pkg::operandT selResult;
    alu_pkg::opcodeT opLatched;
    logic doneQ;

    // Shift amount is the low bits of operand B
    shiftUnit shifter (
        .value   (data1),
        .amount  (data2[$clog2(`ALU_DATA_W)-1:0]),
        .opcode  (op.opcode),
        .shifted (shifted)
    );

    seqMultiplier multiplier (
        .clk          (clk),
        .arstN        (arstN),
        .go           (op.start && (op.opcode == `ALU_OP_MUL)),
        .multiplicand (data1),
        .multiplier   (data2),
        .product      (mulProduct),
        .finish       (mulFinish)
    );

    // Single-cycle operations
    always_comb begin
        case (op.opcode)
            `ALU_OP_FWD: immResult = data2;
            `ALU_OP_ADD: immResult = data1 + data2;
            `ALU_OP_AND: immResult = data1 & data2;
            `ALU_OP_OR: immResult = data1 | data2;
            `ALU_OP_SLL, `ALU_OP_SRA, `ALU_OP_ROR: immResult = shifted;
            // Multiply result comes from the sequencer
            default: immResult = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            opLatched <= `ALU_OP_FWD;
            resultQ <= '0;
            doneQ <= 1'b0;
        end else begin
            if (op.start) begin
                opLatched <= op.opcode;
                resultQ <= immResult;
            end
            // Done one cycle after start except for multiply
            doneQ <= op.start && (op.opcode != `ALU_OP_MUL);
        end
    end

    assign selResult = (opLatched == `ALU_OP_MUL) ? mulProduct : resultQ;
    assign op.result = selResult;
    assign op.zero = (selResult == '0);
    assign op.done = doneQ || mulFinish;

endmodule

//--- aluOpIf.sv
`timescale 1ns/1ps

interface aluOpIf;

    // Request side
    logic start;
    alu_pkg::opcodeT opcode;

    // Completion side
    logic done;
    alu_pkg::operandT result;
    logic zero;

    // Control launches and watches for completion
    modport ctrl (output start, output opcode, input done);

    // Execution unit
    modport exec (input start, input opcode, output done, output result, output zero);

    // Register file only snoops the completion
    modport mon (input done, input result, input zero);

endinterface

//--- alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Datapath and bus widths
`define ALU_DATA_W 8
`define ALU_OP_W 3
`define ALU_ADDR_W 4
`define ALU_AXI_DATA_W 32

// Shift-and-add iterations of the multiplier
`define ALU_MUL_STEPS 8

// Register map byte offsets
`define ALU_REG_DATA1 4'h0
`define ALU_REG_DATA2 4'h4
`define ALU_REG_CTRL 4'h8
`define ALU_REG_STATUS 4'hC

// Opcode encoding of the ALU select lines
`define ALU_OP_FWD 3'd0
`define ALU_OP_ADD 3'd1
`define ALU_OP_AND 3'd2
`define ALU_OP_OR 3'd3
`define ALU_OP_MUL 3'd4
`define ALU_OP_SLL 3'd5
`define ALU_OP_SRA 3'd6
`define ALU_OP_ROR 3'd7

// AXI response codes
`define ALU_RESP_OKAY 2'b00
`define ALU_RESP_SLVERR 2'b10

`endif

//--- alu_pkg.sv
`include "alu_defines.svh"

package alu_pkg;

    // Signed operand and result
    typedef logic signed [`ALU_DATA_W-1:0] operandT;

    // Operation select
    typedef logic [`ALU_OP_W-1:0] opcodeT;

    // Low address bits seen by the register decoder
    typedef logic [`ALU_ADDR_W-1:0] regAddrT;

    // AXI bresp / rresp
    typedef logic [1:0] axiRespT;

    // Bus-side control FSM
    // EXEC is a write response with an operation just launched
    typedef enum logic [1:0] {
        IDLE,
        WRESP,
        RDATA,
        EXEC
    } ctrlStateT;

endpackage

//--- operandRegs.sv
`timescale 1ns/1ps
`include "alu_defines.svh"

module operandRegs (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         wrData1,
    input  logic                         wrData2,
    input  alu_pkg::operandT             wrValue,
    input  logic                         busy,
    aluOpIf.mon                          op,
    output alu_pkg::operandT             data1,
    output alu_pkg::operandT             data2,
    output logic [`ALU_AXI_DATA_W-1:0]   statusWord
);

    alu_pkg::operandT resultQ;
    logic zeroQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            data1 <= '0;
            data2 <= '0;
            resultQ <= '0;
            // Zero result after reset
            zeroQ <= 1'b1;
        end else begin
            if (wrData1) begin
                data1 <= wrValue;
            end
            if (wrData2) begin
                data2 <= wrValue;
            end
            // Captured whatever the bus is doing
            if (op.done) begin
                resultQ <= op.result;
                zeroQ <= op.zero;
            end
        end
    end

    // Busy in bit 9, zero in bit 8, result below
    assign statusWord = {{(`ALU_AXI_DATA_W - `ALU_DATA_W - 2){1'b0}}, busy, zeroQ, resultQ};

endmodule

//--- project.f
+incdir+.
alu_pkg.sv
aluOpIf.sv
shiftUnit.sv
seqMultiplier.sv
aluControl.sv
operandRegs.sv
aluCore.sv
aluCoprocessor.sv
aluCoprocessor_sva.sv
tb_aluCoprocessor.sv

//--- seqMultiplier.sv
`timescale 1ns/1ps
`include "alu_defines.svh"

module seqMultiplier (
    input  logic             clk,
    input  logic             arstN,
    input  logic             go,
    input  alu_pkg::operandT multiplicand,
    input  alu_pkg::operandT multiplier,
    output alu_pkg::operandT product,
    output logic             finish
);

    logic [$clog2(`ALU_MUL_STEPS+1)-1:0] stepCnt;
    logic [`ALU_DATA_W-1:0] mcandQ;
    logic [`ALU_DATA_W-1:0] mplierQ;
    logic [`ALU_DATA_W-1:0] acc;

    // Step counter and finish pulse
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stepCnt <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (go) begin
                stepCnt <= `ALU_MUL_STEPS;
            end else if (stepCnt != '0) begin
                stepCnt <= stepCnt - 1'b1;
                // Last step, product valid next cycle
                if (stepCnt == 1) begin
                    finish <= 1'b1;
                end
            end
        end
    end

    // Shift-and-add datapath
    // Only the low byte is kept, same for signed and unsigned
    always_ff @(posedge clk) begin
        if (go) begin
            acc <= '0;
            mcandQ <= multiplicand;
            mplierQ <= multiplier;
        end else if (stepCnt != '0) begin
            if (mplierQ[0]) begin
                acc <= acc + mcandQ;
            end
            mcandQ <= mcandQ << 1;
            mplierQ <= mplierQ >> 1;
        end
    end

    assign product = acc;

endmodule

//--- shiftUnit.sv
`timescale 1ns/1ps
`include "alu_defines.svh"

module shiftUnit (
    input  alu_pkg::operandT                   value,
    input  logic [$clog2(`ALU_DATA_W)-1:0]     amount,
    input  alu_pkg::opcodeT                    opcode,
    output alu_pkg::operandT                   shifted
);

    logic [2*`ALU_DATA_W-1:0] doubled;
    logic [2*`ALU_DATA_W-1:0] rotated;

    // Rotate via a doubled copy, low half wraps around
    assign doubled = {value, value};
    assign rotated = doubled >> amount;

    always_comb begin
        case (opcode)
            // Zeros shifted in from the right
            `ALU_OP_SLL: shifted = value << amount;
            // Signed operand so the sign bit fills in
            `ALU_OP_SRA: shifted = value >>> amount;
            `ALU_OP_ROR: shifted = rotated[`ALU_DATA_W-1:0];
            default: shifted = value;
        endcase
    end

endmodule

//--- tb_aluCoprocessor.sv
`timescale 1ns/1ps
`include "alu_defines.svh"

module tb_aluCoprocessor;

    // Operations issued over the whole run, for the watchdog
    localparam int NUM_OPS = 62;
    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT_NS = (NUM_OPS * 40 + 100) * CLK_PERIOD;

    logic clk;
    logic arstN;
    logic awvalid;
    logic awready;
    alu_pkg::regAddrT awaddr;
    logic wvalid;
    logic wready;
    logic [`ALU_AXI_DATA_W-1:0] wdata;
    logic bvalid;
    logic bready;
    alu_pkg::axiRespT bresp;
    logic arvalid;
    logic arready;
    alu_pkg::regAddrT araddr;
    logic rvalid;
    logic rready;
    logic [`ALU_AXI_DATA_W-1:0] rdata;
    alu_pkg::axiRespT rresp;

    int mismatches = 0;
    int otherErrors = 0;
    integer seed = 32'hf849_634b;

    aluCoprocessor DUT (
        .clk     (clk),
        .arstN   (arstN),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Reference results, bit by bit from the opcode rules
    function automatic logic [7:0] expectedResult(input alu_pkg::opcodeT op,
                                                  input logic [7:0] a, input logic [7:0] b);
        logic [7:0] r;
        logic [15:0] full;
        int amt;
        int i;
        amt = b[2:0];
        full = a * b;
        r = '0;
        case (op)
            `ALU_OP_FWD: r = b;
            `ALU_OP_ADD: r = a + b;
            `ALU_OP_AND: r = a & b;
            `ALU_OP_OR: r = a | b;
            // Low byte only
            `ALU_OP_MUL: r = full[7:0];
            `ALU_OP_SLL: begin
                for (i = amt; i < 8; i++) begin
                    r[i] = a[i - amt];
                end
            end
            // Vacated upper bits take the sign
            `ALU_OP_SRA: begin
                for (i = 0; i < 8; i++) begin
                    r[i] = (i + amt < 8) ? a[i + amt] : a[7];
                end
            end
            default: begin
                for (i = 0; i < 8; i++) begin
                    r[i] = a[(i + amt) % 8];
                end
            end
        endcase
        return r;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatches++;
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // One write, response held off for stall cycles
    task automatic axiWrite(input alu_pkg::regAddrT addr, input logic [31:0] data,
                            input int stall, output alu_pkg::axiRespT resp);
        @(posedge clk);
        #2;
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        // Address and data go in the same cycle
        do begin
            @(negedge clk);
        end while (!awready);
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid = 1'b0;
        repeat (stall) begin
            @(posedge clk);
            #2;
        end
        bready = 1'b1;
        do begin
            @(negedge clk);
        end while (!bvalid);
        resp = bresp;
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axiRead(input alu_pkg::regAddrT addr, input int stall,
                           output logic [31:0] data, output alu_pkg::axiRespT resp);
        @(posedge clk);
        #2;
        araddr = addr;
        arvalid = 1'b1;
        do begin
            @(negedge clk);
        end while (!arready);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        repeat (stall) begin
            @(posedge clk);
            #2;
        end
        rready = 1'b1;
        do begin
            @(negedge clk);
        end while (!rvalid);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    // Operands, then the opcode into CTRL
    task automatic launchOp(input alu_pkg::opcodeT op, input logic [7:0] a, input logic [7:0] b,
                            input int bStall);
        alu_pkg::axiRespT resp;
        axiWrite(`ALU_REG_DATA1, {24'h0, a}, 0, resp);
        checkValue("DATA1 write resp", `ALU_RESP_OKAY, resp);
        axiWrite(`ALU_REG_DATA2, {24'h0, b}, 0, resp);
        checkValue("DATA2 write resp", `ALU_RESP_OKAY, resp);
        axiWrite(`ALU_REG_CTRL, {29'h0, op}, bStall, resp);
        checkValue("CTRL write resp", `ALU_RESP_OKAY, resp);
    endtask

    // Poll STATUS until busy drops, then compare
    task automatic finishOp(input string name, input alu_pkg::opcodeT op, input logic [7:0] a,
                            input logic [7:0] b, input int rStall);
        logic [31:0] status;
        alu_pkg::axiRespT resp;
        logic [7:0] expected;
        int polls;
        polls = 0;
        do begin
            axiRead(`ALU_REG_STATUS, rStall, status, resp);
            checkValue({name, " status resp"}, `ALU_RESP_OKAY, resp);
            polls++;
        end while (status[9] && polls < 20);
        if (status[9]) begin
            otherErrors++;
            $display("Busy flag never cleared during %s", name);
        end
        expected = expectedResult(op, a, b);
        checkValue(name, expected, status[7:0]);
        checkValue({name, " zero"}, (expected == 8'h00), status[8]);
    endtask

    task automatic runOp(input string name, input alu_pkg::opcodeT op, input logic [7:0] a,
                         input logic [7:0] b);
        launchOp(op, a, b, 0);
        finishOp(name, op, a, b, 0);
    endtask

    initial begin
        logic [31:0] status;
        alu_pkg::axiRespT resp;
        alu_pkg::operandT a;
        alu_pkg::operandT b;
        int i;
        int assertFails;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        arstN = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        arstN = 1'b1;

        // Cleared result with zero set after reset
        axiRead(`ALU_REG_STATUS, 0, status, resp);
        checkValue("reset status", 32'h0000_0100, status);

        // Every opcode on random operands
        for (i = 0; i < 32; i++) begin
            a = $random(seed);
            b = $random(seed);
            runOp("random opcode", alu_pkg::opcodeT'(i % 8), a, b);
        end

        // All amounts, negative value
        for (i = 0; i < 8; i++) begin
            a = $random(seed) | 8'h80;
            runOp("shift left", `ALU_OP_SLL, a, i);
            runOp("arith shift right", `ALU_OP_SRA, a, i);
            runOp("rotate right", `ALU_OP_ROR, a, i);
        end

        // 0x5b * 0x37 needs more than 8 bits
        launchOp(`ALU_OP_MUL, 8'h5b, 8'h37, 0);
        axiRead(`ALU_REG_STATUS, 0, status, resp);
        checkValue("multiply busy flag", 1'b1, status[9]);
        finishOp("multiply overflow", `ALU_OP_MUL, 8'h5b, 8'h37, 0);

        // Rejected writes while the multiplier runs
        launchOp(`ALU_OP_MUL, 8'hc3, 8'h7e, 0);
        axiWrite(`ALU_REG_CTRL, {29'h0, `ALU_OP_ADD}, 0, resp);
        checkValue("CTRL write while busy", `ALU_RESP_SLVERR, resp);
        axiWrite(`ALU_REG_STATUS, 32'h0000_00ff, 0, resp);
        checkValue("STATUS write", `ALU_RESP_SLVERR, resp);
        finishOp("multiply after rejected CTRL", `ALU_OP_MUL, 8'hc3, 8'h7e, 0);

        // Done lands while the write response is stalled
        a = $random(seed);
        b = $random(seed);
        launchOp(`ALU_OP_MUL, a, b, 12);
        finishOp("stalled multiply", `ALU_OP_MUL, a, b, 5);
        a = $random(seed);
        b = $random(seed);
        runOp("add after stalls", `ALU_OP_ADD, a, b);

        repeat (4) @(posedge clk);
        assertFails = DUT.protocolChecks.failCount;
        $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, otherErrors, assertFails);
        if (mismatches == 0 && otherErrors == 0 && assertFails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the DUT stopped responding", TIMEOUT_NS);
        $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, otherErrors + 1, DUT.protocolChecks.failCount);
        $display("Simulation failed");
        $finish;
    end

endmodule
